// File: hw/core_queues.sv
module core_queues
    import memsched_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
)
(
    input  logic                      aclk,
    input  logic                      arst_n,
    input  logic                      wr0_valid,
    input  mem_req_t                  wr0,
    input  core_id_t                  wr0_core,
    input  logic                      wr1_valid,
    input  mem_req_t                  wr1,
    input  core_id_t                  wr1_core,
    input  logic [NUM_CORES-1:0]      pop,
    output mem_req_t [NUM_CORES-1:0]  head,
    output logic [NUM_CORES-1:0]      not_empty,
    output logic [15:0]               drop_count
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   cnt_t;

    mem_req_t             mem [NUM_CORES][QUEUE_DEPTH];
    ptr_t                 rd_ptr [NUM_CORES];
    ptr_t                 wr_ptr [NUM_CORES];
    cnt_t                 count [NUM_CORES];
    logic [NUM_CORES-1:0] acc0;
    logic [NUM_CORES-1:0] acc1;
    logic                 drop0;
    logic                 drop1;
    logic [16:0]          drop_sum;

    ////////////////////
    // Admission, port 0 first

    always_comb
    begin
        for (int c = 0; c < NUM_CORES; c++)
        begin
            acc0[c] = wr0_valid && (wr0_core == core_id_t'(c)) && (count[c] < QUEUE_DEPTH);
            acc1[c] = wr1_valid && (wr1_core == core_id_t'(c))
                      && ((count[c] + cnt_t'(acc0[c])) < QUEUE_DEPTH);
        end
    end

    assign drop0    = wr0_valid && !acc0[wr0_core];
    assign drop1    = wr1_valid && !acc1[wr1_core];
    assign drop_sum = {1'b0, drop_count} + 17'(drop0) + 17'(drop1);

    ////////////////////
    // Pointers and counts

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int c = 0; c < NUM_CORES; c++)
            begin
                rd_ptr[c] <= '0;
                wr_ptr[c] <= '0;
                count[c]  <= '0;
            end
            drop_count <= '0;
        end
        else
        begin
            for (int c = 0; c < NUM_CORES; c++)
            begin
                wr_ptr[c] <= wr_ptr[c] + ptr_t'(acc0[c]) + ptr_t'(acc1[c]);
                if (pop[c])
                begin
                    rd_ptr[c] <= rd_ptr[c] + 1'b1;
                end
                count[c] <= count[c] + cnt_t'(acc0[c]) + cnt_t'(acc1[c]) - cnt_t'(pop[c]);
            end
            // Saturate
            drop_count <= drop_sum[16] ? 16'hffff : drop_sum[15:0];
        end
    end

    always_ff @(posedge aclk)
    begin
        for (int c = 0; c < NUM_CORES; c++)
        begin
            if (acc0[c])
            begin
                mem[c][wr_ptr[c]] <= wr0;
            end
            if (acc1[c])
            begin
                mem[c][wr_ptr[c] + ptr_t'(acc0[c])] <= wr1;
            end
        end
    end

    always_comb
    begin
        for (int c = 0; c < NUM_CORES; c++)
        begin
            head[c]      = mem[c][rd_ptr[c]];
            not_empty[c] = (count[c] != '0);
        end
    end

endmodule

// File: hw/fp_scheduler.sv
module fp_scheduler
    import memsched_pkg::*;
(
    input  logic                      aclk,
    input  logic                      arst_n,
    input  logic                      cfg_we,
    input  core_id_t                  cfg_core,
    input  prio_t                     cfg_prio,
    input  mem_req_t [NUM_CORES-1:0]  head,
    input  logic [NUM_CORES-1:0]      not_empty,
    input  logic                      issue_ready,
    output logic [NUM_CORES-1:0]      pop,
    output logic                      issue_valid,
    output mem_req_t                  issue
);

    prio_t    prio [NUM_CORES];
    prio_t    best;
    core_id_t sel;
    logic     found;

    // Priority registers
    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int c = 0; c < NUM_CORES; c++)
            begin
                prio[c] <= '0;
            end
        end
        else if (cfg_we)
        begin
            prio[cfg_core] <= cfg_prio;
        end
    end

    ////////////////////
    // Selection

    always_comb
    begin
        sel   = '0;
        best  = '0;
        found = 1'b0;
        for (int c = 0; c < NUM_CORES; c++)
        begin
            // Strict compare, ties go to the lower core
            if (not_empty[c] && (!found || (prio[c] > best)))
            begin
                sel   = core_id_t'(c);
                best  = prio[c];
                found = 1'b1;
            end
        end
    end

    assign issue_valid = |not_empty;
    assign issue       = head[sel];

    always_comb
    begin
        pop = '0;
        if (issue_valid && issue_ready)
        begin
            pop[sel] = 1'b1;
        end
    end

endmodule

// File: hw/mem_port.sv
module mem_port
    import memsched_pkg::*;
(
    input  logic     aclk,
    input  logic     arst_n,
    input  logic     issue_valid,
    input  mem_req_t issue,
    output logic     issue_ready,
    output logic     mem_req_valid,
    output mem_req_t mem_req,
    input  logic     mem_req_ready,
    input  logic     mem_rsp_valid,
    input  mem_rsp_t mem_rsp,
    output logic     rsp0_valid,
    output mem_rsp_t rsp0,
    output logic     rsp1_valid,
    output mem_rsp_t rsp1
);

    logic     issue_fire;
    mem_rsp_t rsp_fwd;

    ////////////////////
    // Issue register

    assign issue_ready = !mem_req_valid || mem_req_ready;
    assign issue_fire  = issue_valid && issue_ready;

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mem_req_valid <= 1'b0;
        end
        else if (issue_fire)
        begin
            mem_req_valid <= 1'b1;
        end
        else if (mem_req_ready)
        begin
            mem_req_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (issue_fire)
        begin
            mem_req <= issue;
        end
    end

    ////////////////////
    // Response routing

    // Strip the port tag before handing back
    assign rsp_fwd = '{id: {1'b0, mem_rsp.id[ID_W-2:0]}, data: mem_rsp.data};

    always_comb
    begin
        rsp0_valid = 1'b0;
        rsp0       = '0;
        rsp1_valid = 1'b0;
        rsp1       = '0;
        if (mem_rsp.id[ID_W-1])
        begin
            rsp1_valid = mem_rsp_valid;
            rsp1       = rsp_fwd;
        end
        else
        begin
            rsp0_valid = mem_rsp_valid;
            rsp0       = rsp_fwd;
        end
    end

endmodule

// File: hw/memsched_pkg.sv
package memsched_pkg;

    ////////////////////
    // Widths

    localparam int ADDR_W    = 40;
    localparam int ID_W      = 16;
    localparam int DATA_W    = 128;
    localparam int NUM_CORES = 4;
    localparam int PRIO_W    = 4;

    // Address bits that name the target core
    localparam int CORE_HI = 15;
    localparam int CORE_LO = 14;

    ////////////////////
    // Types

    typedef logic [ADDR_W-1:0]            addr_t;
    typedef logic [ID_W-1:0]              req_id_t;
    typedef logic [DATA_W-1:0]            data_t;
    typedef logic [$clog2(NUM_CORES)-1:0] core_id_t;
    typedef logic [PRIO_W-1:0]            prio_t;

    // Top id bit carries the source client port
    typedef struct packed {
        addr_t   addr;
        req_id_t id;
        logic    is_write;
    } mem_req_t;

    typedef struct packed {
        req_id_t id;
        data_t   data;
    } mem_rsp_t;

endpackage

// File: hw/memsched_top.sv
module memsched_top
    import memsched_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
)
(
    input  logic        aclk,
    input  logic        arst_n,
    input  logic        req0_valid,
    input  mem_req_t    req0,
    input  logic        req1_valid,
    input  mem_req_t    req1,
    input  logic        cfg_we,
    input  core_id_t    cfg_core,
    input  prio_t       cfg_prio,
    output logic        mem_req_valid,
    output mem_req_t    mem_req,
    input  logic        mem_req_ready,
    input  logic        mem_rsp_valid,
    input  mem_rsp_t    mem_rsp,
    output logic        rsp0_valid,
    output mem_rsp_t    rsp0,
    output logic        rsp1_valid,
    output mem_rsp_t    rsp1,
    output logic [15:0] drop_count
);

    logic                     pkt0_valid;
    mem_req_t                 pkt0;
    core_id_t                 pkt0_core;
    logic                     pkt1_valid;
    mem_req_t                 pkt1;
    core_id_t                 pkt1_core;
    mem_req_t [NUM_CORES-1:0] head;
    logic [NUM_CORES-1:0]     not_empty;
    logic [NUM_CORES-1:0]     pop;
    logic                     issue_valid;
    mem_req_t                 issue;
    logic                     issue_ready;

    ////////////////////
    // Client side

    request_packetizer #(
        .PORT_SEL(1'b0)
    ) u_pkt0 (
        .aclk(aclk),
        .arst_n(arst_n),
        .req_valid(req0_valid),
        .req(req0),
        .pkt_valid(pkt0_valid),
        .pkt(pkt0),
        .pkt_core(pkt0_core)
    );

    request_packetizer #(
        .PORT_SEL(1'b1)
    ) u_pkt1 (
        .aclk(aclk),
        .arst_n(arst_n),
        .req_valid(req1_valid),
        .req(req1),
        .pkt_valid(pkt1_valid),
        .pkt(pkt1),
        .pkt_core(pkt1_core)
    );

    ////////////////////
    // Queueing and scheduling

    core_queues #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_core_queues (
        .aclk(aclk),
        .arst_n(arst_n),
        .wr0_valid(pkt0_valid),
        .wr0(pkt0),
        .wr0_core(pkt0_core),
        .wr1_valid(pkt1_valid),
        .wr1(pkt1),
        .wr1_core(pkt1_core),
        .pop(pop),
        .head(head),
        .not_empty(not_empty),
        .drop_count(drop_count)
    );

    fp_scheduler u_fp_scheduler (
        .aclk(aclk),
        .arst_n(arst_n),
        .cfg_we(cfg_we),
        .cfg_core(cfg_core),
        .cfg_prio(cfg_prio),
        .head(head),
        .not_empty(not_empty),
        .issue_ready(issue_ready),
        .pop(pop),
        .issue_valid(issue_valid),
        .issue(issue)
    );

    ////////////////////
    // Memory side

    mem_port u_mem_port (
        .aclk(aclk),
        .arst_n(arst_n),
        .issue_valid(issue_valid),
        .issue(issue),
        .issue_ready(issue_ready),
        .mem_req_valid(mem_req_valid),
        .mem_req(mem_req),
        .mem_req_ready(mem_req_ready),
        .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp(mem_rsp),
        .rsp0_valid(rsp0_valid),
        .rsp0(rsp0),
        .rsp1_valid(rsp1_valid),
        .rsp1(rsp1)
    );

endmodule

// File: hw/request_packetizer.sv
module request_packetizer
    import memsched_pkg::*;
#(
    parameter bit PORT_SEL = 1'b0
)
(
    input  logic     aclk,
    input  logic     arst_n,
    input  logic     req_valid,
    input  mem_req_t req,
    output logic     pkt_valid,
    output mem_req_t pkt,
    output core_id_t pkt_core
);

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pkt_valid <= 1'b0;
        end
        else
        begin
            pkt_valid <= req_valid;
        end
    end

    // Tag with the source port so the response finds its way back
    always_ff @(posedge aclk)
    begin
        if (req_valid)
        begin
            pkt.addr     <= req.addr;
            pkt.id       <= {PORT_SEL, req.id[ID_W-2:0]};
            pkt.is_write <= req.is_write;
        end
    end

    // Core number sits in the address
    assign pkt_core = pkt.addr[CORE_HI:CORE_LO];

endmodule

// File: tb/memsched_stim.txt
// op_arg_addr_id_value. op 1 request (arg port, 2 = both), 2 priority (arg core), 3 hold ready,
// 4 release, 5 response (value = data word), 6 expect issue, 7 expect drops. value bit 0 = is_write
1_1_0000A04000_0011_00000001
6_0_0000A04000_8011_00000001
3_0_0000000000_0000_00000000
1_0_0000000100_0020_00000000
6_0_0000000100_0020_00000000
1_0_0000004200_0021_00000000
1_1_0000008300_0022_00000001
1_0_000000C400_0023_00000000
2_2_0000000000_0000_00000007
2_3_0000000000_0000_00000005
2_1_0000000000_0000_00000005
6_0_0000008300_8022_00000001
6_0_0000004200_0021_00000000
6_0_000000C400_0023_00000000
4_0_0000000000_0000_00000000
5_0_0000000000_0033_12345678
5_0_0000000000_8044_9ABCDEF0
3_0_0000000000_0000_00000000
1_0_000000C010_0050_00000000
6_0_000000C010_0050_00000000
1_0_0000004010_0051_00000000
1_0_0000004020_0052_00000001
1_0_0000004030_0053_00000000
1_0_0000004040_0054_00000001
1_0_0000004050_0055_00000000
1_0_0000004060_0056_00000000
6_0_0000004010_0051_00000000
6_0_0000004020_0052_00000001
6_0_0000004030_0053_00000000
6_0_0000004040_0054_00000001
4_0_0000000000_0000_00000000
7_0_0000000000_0000_00000002
1_2_0000008070_0060_00000000
6_0_0000008070_0060_00000000
6_0_0000008070_8060_00000000
7_0_0000000000_0000_00000002

// File: tb/memsched_sva.sv
module memsched_sva
    import memsched_pkg::*;
(
    input logic                 aclk,
    input logic                 arst_n,
    input logic                 mem_req_valid,
    input logic                 mem_req_ready,
    input mem_req_t             mem_req,
    input logic [NUM_CORES-1:0] pop,
    input logic                 rsp0_valid,
    input logic                 rsp1_valid
);

    // Stalled request must not move
    a_req_stable: assert property (@(posedge aclk) disable iff (!arst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("mem_req changed while stalled");

    a_pop_onehot: assert property (@(posedge aclk) disable iff (!arst_n) $onehot0(pop))
        else $error("pop has more than one bit set");

    a_rsp_excl: assert property (@(posedge aclk) disable iff (!arst_n)
        !(rsp0_valid && rsp1_valid))
        else $error("rsp0_valid and rsp1_valid high together");

endmodule

bind memsched_top memsched_sva u_memsched_sva (
    .aclk(aclk),
    .arst_n(arst_n),
    .mem_req_valid(mem_req_valid),
    .mem_req_ready(mem_req_ready),
    .mem_req(mem_req),
    .pop(pop),
    .rsp0_valid(rsp0_valid),
    .rsp1_valid(rsp1_valid)
);

// File: tb/tb_memsched.sv
module tb_memsched
    import memsched_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int QUEUE_DEPTH = 4;
    localparam int STIM_MAX    = 64;
    localparam int DRAIN_MAX   = 200;

    logic        aclk;
    logic        arst_n;
    logic        req0_valid;
    mem_req_t    req0;
    logic        req1_valid;
    mem_req_t    req1;
    logic        cfg_we;
    core_id_t    cfg_core;
    prio_t       cfg_prio;
    logic        mem_req_valid;
    mem_req_t    mem_req;
    logic        mem_req_ready;
    logic        mem_rsp_valid;
    mem_rsp_t    mem_rsp;
    logic        rsp0_valid;
    mem_rsp_t    rsp0;
    logic        rsp1_valid;
    mem_rsp_t    rsp1;
    logic [15:0] drop_count;

    logic [95:0] stim [STIM_MAX];
    int          n_lines;
    int          seed = 86358;
    int          errors;
    int          checks;
    logic        hold_ready;

    ////////////////////
    // Reference model

    mem_req_t    mq [NUM_CORES][QUEUE_DEPTH];
    int          mq_cnt [NUM_CORES];
    prio_t       mprio [NUM_CORES];
    int          model_drops;
    mem_req_t    exp_q [STIM_MAX];
    int          exp_wr;
    int          exp_rd;

    memsched_top #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_memsched_top (
        .aclk(aclk),
        .arst_n(arst_n),
        .req0_valid(req0_valid),
        .req0(req0),
        .req1_valid(req1_valid),
        .req1(req1),
        .cfg_we(cfg_we),
        .cfg_core(cfg_core),
        .cfg_prio(cfg_prio),
        .mem_req_valid(mem_req_valid),
        .mem_req(mem_req),
        .mem_req_ready(mem_req_ready),
        .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp(mem_rsp),
        .rsp0_valid(rsp0_valid),
        .rsp0(rsp0),
        .rsp1_valid(rsp1_valid),
        .rsp1(rsp1),
        .drop_count(drop_count)
    );

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    task automatic check_req(input string name, input mem_req_t exp, input mem_req_t got);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_rsp(input string name, input mem_rsp_t exp, input mem_rsp_t got);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_num(input string name, input logic [15:0] exp, input logic [15:0] got);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    // Strobes last one cycle and ready is random unless held
    task automatic next_cycle();
        int r;
        @(posedge aclk);
        #2;
        r = $random(seed);
        req0_valid    = 1'b0;
        req1_valid    = 1'b0;
        cfg_we        = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_req_ready = hold_ready ? 1'b0 : r[0];
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_rd != exp_wr && n < DRAIN_MAX)
        begin
            next_cycle();
            n++;
        end
        if (exp_rd != exp_wr)
        begin
            errors++;
            $display("Expected requests never reached the memory port by t=%0t", $time);
        end
    endtask

    task automatic model_push(input mem_req_t r, input logic port);
        core_id_t c;
        r.id[ID_W-1] = port;
        c = r.addr[CORE_HI:CORE_LO];
        if (mq_cnt[c] < QUEUE_DEPTH)
        begin
            mq[c][mq_cnt[c]] = r;
            mq_cnt[c]++;
        end
        else
        begin
            model_drops++;
        end
    endtask

    // Highest priority wins with ties to the lower core and FIFO order inside a core
    task automatic model_pick(output mem_req_t r, output logic ok);
        int top;
        int best;
        top  = -1;
        best = -1;
        r    = '0;
        ok   = 1'b0;
        for (int c = 0; c < NUM_CORES; c++)
        begin
            if (mq_cnt[c] > 0 && int'(mprio[c]) > top)
            begin
                top = int'(mprio[c]);
            end
        end
        for (int c = 0; c < NUM_CORES; c++)
        begin
            if (best < 0 && mq_cnt[c] > 0 && int'(mprio[c]) == top)
            begin
                best = c;
            end
        end
        if (best >= 0)
        begin
            r = mq[best][0];
            for (int i = 1; i < mq_cnt[best]; i++)
            begin
                mq[best][i-1] = mq[best][i];
            end
            mq_cnt[best]--;
            ok = 1'b1;
        end
    endtask

    task automatic run_line(input logic [95:0] w);
        logic [3:0]  op;
        logic [3:0]  arg;
        logic [31:0] val;
        mem_req_t    r;
        mem_req_t    pick;
        mem_rsp_t    exp_rsp;
        logic        ok;
        op         = w[95:92];
        arg        = w[91:88];
        val        = w[31:0];
        r.addr     = w[87:48];
        r.id       = w[47:32];
        r.is_write = w[0];
        case (op)
            4'h1:
            begin
                next_cycle();
                if (arg != 4'd1)
                begin
                    req0_valid = 1'b1;
                    req0       = r;
                    model_push(r, 1'b0);
                end
                if (arg != 4'd0)
                begin
                    req1_valid = 1'b1;
                    req1       = r;
                    model_push(r, 1'b1);
                end
            end
            4'h2:
            begin
                next_cycle();
                cfg_we          = 1'b1;
                cfg_core        = arg[1:0];
                cfg_prio        = val[PRIO_W-1:0];
                mprio[arg[1:0]] = val[PRIO_W-1:0];
            end
            4'h3:
            begin
                wait_drain();
                hold_ready = 1'b1;
                next_cycle();
            end
            4'h4:
            begin
                hold_ready = 1'b0;
                next_cycle();
            end
            4'h5:
            begin
                next_cycle();
                mem_rsp_valid = 1'b1;
                mem_rsp.id    = r.id;
                mem_rsp.data  = {4{val}};
                exp_rsp.id    = r.id;
                exp_rsp.id[ID_W-1] = 1'b0;
                exp_rsp.data  = {4{val}};
                #5;
                check_num("rsp0_valid", 16'(!r.id[ID_W-1]), 16'(rsp0_valid));
                check_num("rsp1_valid", 16'(r.id[ID_W-1]), 16'(rsp1_valid));
                check_rsp("rsp0", r.id[ID_W-1] ? '0 : exp_rsp, rsp0);
                check_rsp("rsp1", r.id[ID_W-1] ? exp_rsp : '0, rsp1);
            end
            4'h6:
            begin
                model_pick(pick, ok);
                if (!ok)
                begin
                    errors++;
                    $display("Expect-issue line found no queued request in the model");
                end
                else
                begin
                    check_req("model issue", r, pick);
                    exp_q[exp_wr] = pick;
                    exp_wr++;
                end
            end
            4'h7:
            begin
                wait_drain();
                check_num("drop_count", val[15:0], drop_count);
                check_num("model drop count", val[15:0], 16'(model_drops));
            end
            default:
            begin
                errors++;
                $display("Unknown opcode %h in the stimulus file", op);
            end
        endcase
    endtask

    // Memory side transfers are compared in order against the model
    always @(negedge aclk)
    begin
        if (arst_n && mem_req_valid && mem_req_ready)
        begin
            if (exp_rd == exp_wr)
            begin
                errors++;
                $display("Unexpected memory request %h at t=%0t", mem_req, $time);
            end
            else
            begin
                check_req("mem_req", exp_q[exp_rd], mem_req);
                exp_rd++;
            end
        end
    end

    initial
    begin
        #1;
        #(CLK_PERIOD * (n_lines * 20 + 100));
        $display("Timeout, the run did not finish by t=%0t", $time);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Some tests failed");
        $finish;
    end

    initial
    begin
        aclk          = 1'b0;
        arst_n        = 1'b0;
        req0_valid    = 1'b0;
        req0          = '0;
        req1_valid    = 1'b0;
        req1          = '0;
        cfg_we        = 1'b0;
        cfg_core      = '0;
        cfg_prio      = '0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        hold_ready    = 1'b0;
        errors        = 0;
        checks        = 0;
        model_drops   = 0;
        exp_wr        = 0;
        exp_rd        = 0;
        for (int c = 0; c < NUM_CORES; c++)
        begin
            mq_cnt[c] = 0;
            mprio[c]  = '0;
        end
        for (int i = 0; i < STIM_MAX; i++)
        begin
            stim[i] = '0;
        end
        $readmemh("tb/memsched_stim.txt", stim);
        n_lines = 0;
        while (n_lines < STIM_MAX && stim[n_lines][95:92] != 4'h0)
        begin
            n_lines++;
        end

        repeat (3) @(posedge aclk);
        #2;
        arst_n = 1'b1;
        check_num("mem_req_valid", 16'h0, 16'(mem_req_valid));
        check_num("rsp0_valid", 16'h0, 16'(rsp0_valid));
        check_num("rsp1_valid", 16'h0, 16'(rsp1_valid));
        check_num("drop_count", 16'h0, drop_count);

        for (int i = 0; i < n_lines; i++)
        begin
            run_line(stim[i]);
        end
        hold_ready = 1'b0;
        wait_drain();

        $display("Checks: %0d, errors: %0d, drops: %0d", checks, errors, drop_count);
        if (errors == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
hw/memsched_pkg.sv
hw/request_packetizer.sv
hw/core_queues.sv
hw/fp_scheduler.sv
hw/mem_port.sv
hw/memsched_top.sv
tb/memsched_sva.sv
tb/tb_memsched.sv
